/* dv/FetchUnitTb.sv */
//--------------------------------------------------------------------------
// Table-driven testbench for the fetch unit.
// Test pcs start on a line, so the one extra lookup at pc+4 that runs
// before the stall takes hold stays inside the line just filled.
// Memory returns each 32-bit word equal to its own byte address.
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module FetchUnitTb;
    import FetchTypes::*;
    import CacheTypes::*;

    typedef enum {
        OpTlbWrite,
        OpFetch,
        OpResume,
        OpInvalidateICache,
        OpInvalidateTlb,
        OpRequests
    } StepOp;

    typedef enum {
        ExpValid,
        ExpFault,
        ExpMiss
    } Outcome;

    typedef struct {
        StepOp   op;
        VirtAddr addr;
        PhysPage phys;
        logic    exec;
        Outcome  outcome;
        int      requests;
        string   name;
    } Step;

    logic     clk = 1'b0;
    logic     rst = 1'b1;
    logic     valid;
    logic     fault;
    logic     tlbMiss;
    VirtAddr  pc;
    CacheLine line;
    logic     stall = 1'b1;
    logic     flush = 1'b0;
    VirtAddr  nextPc = '0;
    logic     memReadReq;
    PhysAddr  memAddr;
    logic     memReadGrant = 1'b0;
    CacheLine memReadLine = '0;
    logic     tlbWrite = 1'b0;
    VirtPage  tlbWriteVirt = '0;
    PhysPage  tlbWritePhys = '0;
    logic     tlbWriteExec = 1'b0;
    logic     invalidateICache = 1'b0;
    logic     invalidateTlb = 1'b0;

    Step         steps[$];
    int          errors = 0;
    int          checks = 0;
    int          requestCount = 0;
    logic [31:0] lfsr = 32'h3268;
    logic        memBusy = 1'b0;
    logic [3:0]  memWait = '0;

    FetchUnit #(
        .tlbEntries(4),
        .initialPc (32'h0000_1000)
    ) i_dut (
        .clk,
        .rst,
        .valid,
        .fault,
        .tlbMiss,
        .pc,
        .line,
        .stall,
        .flush,
        .nextPc,
        .memReadReq,
        .memAddr,
        .memReadGrant,
        .memReadLine,
        .tlbWrite,
        .tlbWriteVirt,
        .tlbWritePhys,
        .tlbWriteExec,
        .invalidateICache,
        .invalidateTlb
    );

    always #50 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    function automatic CacheLine wordsFrom(input PhysAddr base);
        CacheLine result;
        for (int i = 0; i < lineBytes / 4; i++) begin
            result[32*i +: 32] = base + 32'(4 * i);
        end
        return result;
    endfunction

    // Memory with a random grant delay of 1 to 8 cycles
    always @(posedge clk) begin : memoryModel
        logic [2:0] delayBits;
        if (rst) begin
            memBusy      <= 1'b0;
            memReadGrant <= 1'b0;
            memWait      <= '0;
        end else if (memReadGrant) begin
            memReadGrant <= 1'b0;
            memBusy      <= 1'b0;
        end else if (memBusy) begin
            if (memWait == 4'd1) begin
                memReadGrant <= 1'b1;
                memReadLine  <= wordsFrom(memAddr);
            end
            memWait <= memWait - 4'd1;
        end else if (memReadReq) begin
            for (int i = 0; i < 3; i++) begin
                lfsr      = lfsrNext(lfsr);
                delayBits = {delayBits[1:0], lfsr[0]};
            end
            memBusy      <= 1'b1;
            memWait      <= 4'd1 + 4'(delayBits);
            requestCount <= requestCount + 1;
        end
    end

    task automatic addStep(input StepOp op, input VirtAddr addr, input PhysPage phys,
                           input logic exec, input Outcome outcome, input int requests,
                           input string name);
        Step s;
        s.op       = op;
        s.addr     = addr;
        s.phys     = phys;
        s.exec     = exec;
        s.outcome  = outcome;
        s.requests = requests;
        s.name     = name;
        steps.push_back(s);
    endtask

    task automatic buildSteps();
        addStep(OpTlbWrite, 32'h0001_0000, 20'h80020, 1'b1, ExpValid, 0, "map code page");
        addStep(OpFetch, 32'h0001_0040, 20'h80020, 1'b0, ExpValid, 0, "translate first line");
        addStep(OpRequests, '0, '0, 1'b0, ExpValid, 1, "refill of first line");
        addStep(OpFetch, 32'h0001_0120, 20'h80020, 1'b0, ExpValid, 0, "second line");
        addStep(OpRequests, '0, '0, 1'b0, ExpValid, 2, "refill of second line");
        addStep(OpFetch, 32'h0001_0040, 20'h80020, 1'b0, ExpValid, 0, "refetch cached line");
        addStep(OpRequests, '0, '0, 1'b0, ExpValid, 2, "cached line reuse");
        addStep(OpFetch, 32'h0001_1200, '0, 1'b0, ExpMiss, 0, "unmapped page");
        addStep(OpTlbWrite, 32'h0001_1000, 20'h80031, 1'b1, ExpValid, 0, "map second page");
        addStep(OpResume, 32'h0001_1200, 20'h80031, 1'b0, ExpValid, 0, "retry after tlb write");
        addStep(OpRequests, '0, '0, 1'b0, ExpValid, 3, "refill after tlb miss");
        addStep(OpTlbWrite, 32'h0001_2000, 20'h80044, 1'b0, ExpValid, 0, "map data page");
        addStep(OpFetch, 32'h0001_2300, 20'h80044, 1'b0, ExpFault, 0, "fetch without exec");
        addStep(OpRequests, '0, '0, 1'b0, ExpValid, 3, "no refill on fault");
        addStep(OpInvalidateICache, '0, '0, 1'b0, ExpValid, 0, "invalidate cache");
        addStep(OpFetch, 32'h0001_0040, 20'h80020, 1'b0, ExpValid, 0, "refetch after sweep");
        addStep(OpRequests, '0, '0, 1'b0, ExpValid, 4, "one refill after sweep");
        addStep(OpInvalidateTlb, '0, '0, 1'b0, ExpValid, 0, "invalidate tlb");
        addStep(OpFetch, 32'h0001_0040, '0, 1'b0, ExpMiss, 0, "fetch after tlb clear");
        addStep(OpRequests, '0, '0, 1'b0, ExpValid, 4, "no refill on tlb miss");
    endtask

    task automatic checkValue(input string name, input string what,
                              input logic [127:0] expected, input logic [127:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("ERR %s %s: expected %0h actual %0h", name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic fetchAndCheck(input Step s, input logic useFlush);
        PhysAddr  lineBase;
        CacheLine expectedLine;
        lineBase     = {s.phys, s.addr[pageOffsetWidth-1:lineOffsetWidth],
                        {lineOffsetWidth{1'b0}}};
        expectedLine = wordsFrom(lineBase);
        @(posedge clk);
        stall <= 1'b0;
        if (useFlush) begin
            flush  <= 1'b1;
            nextPc <= s.addr;
        end
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        // Refill latency varies, the watchdog bounds this
        while (!valid && !tlbMiss) begin
            @(negedge clk);
        end
        checkValue(s.name, "valid", s.outcome != ExpMiss, valid);
        checkValue(s.name, "fault", s.outcome == ExpFault, fault);
        checkValue(s.name, "tlbMiss", s.outcome == ExpMiss, tlbMiss);
        checkValue(s.name, "pc", s.addr, pc);
        if (s.outcome == ExpValid) begin
            checkValue(s.name, "line", expectedLine, line);
            @(negedge clk);
            checkValue(s.name, "next valid", 1'b1, valid);
            checkValue(s.name, "next pc", s.addr + 32'd4, pc);
            checkValue(s.name, "next line", expectedLine, line);
        end
        @(posedge clk);
        stall <= 1'b1;
    endtask

    task automatic applyStep(input Step s);
        case (s.op)
            OpTlbWrite: begin
                @(posedge clk);
                tlbWrite     <= 1'b1;
                tlbWriteVirt <= s.addr[31:pageOffsetWidth];
                tlbWritePhys <= s.phys;
                tlbWriteExec <= s.exec;
                @(posedge clk);
                tlbWrite <= 1'b0;
            end
            OpFetch: fetchAndCheck(s, 1'b1);
            OpResume: fetchAndCheck(s, 1'b0);
            OpInvalidateICache: begin
                @(posedge clk);
                invalidateICache <= 1'b1;
                @(posedge clk);
                invalidateICache <= 1'b0;
                // Sweep runs one line per cycle
                repeat (2 ** indexWidth + 2) @(posedge clk);
            end
            OpInvalidateTlb: begin
                @(posedge clk);
                invalidateTlb <= 1'b1;
                @(posedge clk);
                invalidateTlb <= 1'b0;
            end
            OpRequests: begin
                @(negedge clk);
                checkValue(s.name, "memory requests", s.requests, requestCount);
            end
            default: begin
                $display("Unknown step operation in step %s", s.name);
                errors++;
            end
        endcase
    endtask

    initial begin
        buildSteps();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        foreach (steps[i]) begin
            applyStep(steps[i]);
        end
        repeat (2) @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        @(negedge rst);
        repeat (steps.size() * 200) @(posedge clk);
        $display("Timeout: no result from the fetch unit within %0d cycles",
                 steps.size() * 200);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the fetch unit testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f \
    --top-module FetchUnitTb \
    -o FetchUnitTbSim

./obj_dir/FetchUnitTbSim | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    echo "Testbench reported failure"
    exit 1
fi

echo "Run complete, see sim.log"

/* source/CacheTypes.sv */
//--------------------------------------------------------------------------
// Geometry of the direct-mapped instruction cache: 64 lines of 16 bytes.
// Index and line offset together must fit inside the 12-bit page offset,
// since the array is indexed before translation finishes.
//--------------------------------------------------------------------------
`default_nettype none

package CacheTypes;

    localparam int lineBytes = 16;
    localparam int lineOffsetWidth = $clog2(lineBytes);
    localparam int indexWidth = 6;

    // Physical address is 32 bits
    localparam int lineAddrWidth = 32 - lineOffsetWidth;
    localparam int tagWidth = lineAddrWidth - indexWidth;

    typedef logic [indexWidth-1:0] CacheIndex;
    typedef logic [tagWidth-1:0] CacheTag;
    typedef logic [lineBytes*8-1:0] CacheLine;
    typedef logic [lineAddrWidth-1:0] LineAddr;

endpackage

`default_nettype wire

/* source/FetchTypes.sv */
//--------------------------------------------------------------------------
// Address and page types for instruction address translation.
// Virtual and physical addresses are both 32 bits with 4 KiB pages, so
// the page number is 20 bits on either side of the TLB.
//--------------------------------------------------------------------------
`default_nettype none

package FetchTypes;

    localparam int addrWidth = 32;

    // 4 KiB pages
    localparam int pageOffsetWidth = 12;

    localparam int pageNumberWidth = addrWidth - pageOffsetWidth;

    typedef logic [addrWidth-1:0] VirtAddr;
    typedef logic [addrWidth-1:0] PhysAddr;

    typedef logic [pageNumberWidth-1:0] VirtPage;
    typedef logic [pageNumberWidth-1:0] PhysPage;

endpackage

`default_nettype wire

/* source/FetchUnit.sv */
//--------------------------------------------------------------------------
// Instruction fetch: TLB lookup and cache read of the next pc in cycle n,
// result on valid, fault or tlbMiss in cycle n+1, one 128-bit line per pc.
// The pc steps by 4 only; no compressed instructions, no privilege checks.
// TLB entries are filled by software, a miss just retries each cycle.
// A faulting pc is held until software flushes to a new address.
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module FetchUnit #(
    parameter int                  tlbEntries = 4,
    parameter FetchTypes::VirtAddr initialPc  = 32'h0000_0000
) (
    input  logic                 clk,
    input  logic                 rst,
    output logic                 valid,
    output logic                 fault,
    output logic                 tlbMiss,
    output FetchTypes::VirtAddr  pc,
    output CacheTypes::CacheLine line,
    input  logic                 stall,
    input  logic                 flush,
    input  FetchTypes::VirtAddr  nextPc,
    output logic                 memReadReq,
    output FetchTypes::PhysAddr  memAddr,
    input  logic                 memReadGrant,
    input  CacheTypes::CacheLine memReadLine,
    input  logic                 tlbWrite,
    input  FetchTypes::VirtPage  tlbWriteVirt,
    input  FetchTypes::PhysPage  tlbWritePhys,
    input  logic                 tlbWriteExec,
    input  logic                 invalidateICache,
    input  logic                 invalidateTlb
);
    import FetchTypes::*;
    import CacheTypes::*;

    typedef enum logic [1:0] {
        Default,
        Invalidate,
        Refill
    } FetchState;

    FetchState state;
    FetchState nextState;
    VirtAddr   lookupPc;
    logic      lookup;
    logic      holdResult;
    logic      pendingInvalidate;
    logic      invalidateRequest;

    // Registered lookup results, shown in the cycle after the lookup
    logic    resultValid;
    logic    resultTlbMiss;
    logic    resultFault;
    LineAddr resultLineAddr;

    logic [tlbEntries-1:0]    entryWrite;
    logic                     entryClear;
    logic [tlbEntries-1:0]    entryMatch;
    PhysPage [tlbEntries-1:0] entryPhys;
    logic [tlbEntries-1:0]    entryExec;
    logic                     tlbHit;
    PhysPage                  tlbPhysPage;
    logic                     tlbExec;

    logic      readValid;
    CacheTag   readTag;
    logic      arrayWrite;
    CacheIndex arrayWriteIndex;
    CacheTag   arrayWriteTag;
    CacheLine  arrayWriteLine;
    logic      sweepDone;
    logic      cacheHit;
    logic      cacheMiss;
    logic      refillStart;
    logic      refillDone;

    TlbAllocator #(
        .tlbEntries(tlbEntries)
    ) i_allocator (
        .clk,
        .rst,
        .tlbWrite,
        .invalidateTlb,
        .entryWrite,
        .entryClear
    );

    for (genvar i = 0; i < tlbEntries; i++) begin : entrySlot
        TlbEntry i_entry (
            .clk,
            .rst,
            .write     (entryWrite[i]),
            .clear     (entryClear),
            .writeVirt (tlbWriteVirt),
            .writePhys (tlbWritePhys),
            .writeExec (tlbWriteExec),
            .lookupPage(lookupPc[$bits(VirtAddr)-1:pageOffsetWidth]),
            .match     (entryMatch[i]),
            .physPage  (entryPhys[i]),
            .exec      (entryExec[i])
        );
    end

    TlbHitMerge #(
        .tlbEntries(tlbEntries)
    ) i_hitMerge (
        .match    (entryMatch),
        .physPages(entryPhys),
        .execs    (entryExec),
        .hit      (tlbHit),
        .physPage (tlbPhysPage),
        .exec     (tlbExec)
    );

    // Index comes from the page offset, so no need to wait for the TLB
    ICacheArray i_array (
        .clk,
        .rst,
        .readIndex  (lookupPc[lineOffsetWidth +: indexWidth]),
        .readValid,
        .readTag,
        .readLine   (line),
        .writeEnable(arrayWrite),
        .writeIndex (arrayWriteIndex),
        .writeTag   (arrayWriteTag),
        .writeLine  (arrayWriteLine),
        .sweep      (state == Invalidate),
        .sweepDone
    );

    ICacheRefill i_refill (
        .clk,
        .rst,
        .start      (refillStart),
        .missAddr   (resultLineAddr),
        .memReadReq,
        .memAddr,
        .memReadGrant,
        .memReadLine,
        .writeEnable(arrayWrite),
        .writeIndex (arrayWriteIndex),
        .writeTag   (arrayWriteTag),
        .writeLine  (arrayWriteLine),
        .done       (refillDone)
    );

    always_comb begin
        cacheHit  = readValid && (readTag == resultLineAddr[$bits(LineAddr)-1:indexWidth]);
        cacheMiss = resultValid && !resultTlbMiss && !resultFault && !cacheHit;
        valid     = resultValid && !resultTlbMiss && (resultFault || cacheHit);
        fault     = resultFault;
        tlbMiss   = resultTlbMiss;

        invalidateRequest = invalidateICache || pendingInvalidate;
        // A flush drops the missing line instead of refilling it
        refillStart = (state == Default) && cacheMiss && !flush && !invalidateRequest;
        lookup      = (state == Default) && !stall && !invalidateRequest && !refillStart;
        holdResult  = (state == Default) && stall && !flush;

        if (flush) begin
            lookupPc = nextPc;
        end else if (state == Default && valid && !fault && !stall) begin
            lookupPc = pc + 32'd4;
        end else begin
            lookupPc = pc;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            Default: begin
                if (invalidateRequest) begin
                    nextState = Invalidate;
                end else if (refillStart) begin
                    nextState = Refill;
                end
            end
            // Sweep waits for the refill to finish
            Refill: begin
                if (refillDone) begin
                    nextState = invalidateRequest ? Invalidate : Default;
                end
            end
            Invalidate: begin
                if (sweepDone) begin
                    nextState = Default;
                end
            end
            default: nextState = Default;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state             <= Default;
            pc                <= initialPc;
            pendingInvalidate <= 1'b0;
        end else begin
            state             <= nextState;
            pc                <= lookupPc;
            pendingInvalidate <= invalidateRequest
                && !(nextState == Invalidate && state != Invalidate);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resultValid   <= 1'b0;
            resultTlbMiss <= 1'b0;
            resultFault   <= 1'b0;
        end else if (!holdResult) begin
            resultValid   <= lookup;
            resultTlbMiss <= lookup && !tlbHit;
            resultFault   <= lookup && tlbHit && !tlbExec;
        end
    end

    always_ff @(posedge clk) begin
        if (!holdResult) begin
            resultLineAddr <= {tlbPhysPage, lookupPc[pageOffsetWidth-1:lineOffsetWidth]};
        end
    end

    // Refill must be idle before a new miss is taken
    assert property (@(posedge clk) disable iff (rst) refillStart |-> !memReadReq)
        else $error("FetchUnit: refill started while a request is pending");

endmodule

`default_nettype wire

/* source/ICacheArray.sv */
//--------------------------------------------------------------------------
// Valid, tag and data storage of the instruction cache.
// Reads are registered: the index of cycle n gives its result in n+1.
// A write and a read of the same index in one cycle return the old line.
// The sweep clears one valid bit per cycle, 64 cycles for the whole array.
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module ICacheArray (
    input  logic                  clk,
    input  logic                  rst,
    input  CacheTypes::CacheIndex readIndex,
    output logic                  readValid,
    output CacheTypes::CacheTag   readTag,
    output CacheTypes::CacheLine  readLine,
    input  logic                  writeEnable,
    input  CacheTypes::CacheIndex writeIndex,
    input  CacheTypes::CacheTag   writeTag,
    input  CacheTypes::CacheLine  writeLine,
    input  logic                  sweep,
    output logic                  sweepDone
);
    import CacheTypes::*;

    localparam int lineCount = 2 ** indexWidth;

    logic [lineCount-1:0] valids;
    CacheTag              tags [lineCount];
    CacheLine             lines [lineCount];
    CacheIndex            sweepIndex;

    // Tag and data RAMs
    always_ff @(posedge clk) begin
        if (writeEnable) begin
            tags[writeIndex]  <= writeTag;
            lines[writeIndex] <= writeLine;
        end
        readTag  <= tags[readIndex];
        readLine <= lines[readIndex];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valids     <= '0;
            readValid  <= 1'b0;
            sweepIndex <= '0;
        end else begin
            if (sweep) begin
                valids[sweepIndex] <= 1'b0;
                sweepIndex         <= sweepIndex + 1'b1;
            end else if (writeEnable) begin
                valids[writeIndex] <= 1'b1;
            end
            readValid <= valids[readIndex];
        end
    end

    // Counter wraps back to 0 on the last index
    assign sweepDone = sweep && (sweepIndex == CacheIndex'(lineCount - 1));

endmodule

`default_nettype wire

/* source/ICacheRefill.sv */
//--------------------------------------------------------------------------
// Line refill from memory for one cache miss at a time.
// The request is a level held with a steady address until the grant
// pulse; the line on memReadLine is taken in the grant cycle.
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module ICacheRefill (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  CacheTypes::LineAddr   missAddr,
    output logic                  memReadReq,
    output FetchTypes::PhysAddr   memAddr,
    input  logic                  memReadGrant,
    input  CacheTypes::CacheLine  memReadLine,
    output logic                  writeEnable,
    output CacheTypes::CacheIndex writeIndex,
    output CacheTypes::CacheTag   writeTag,
    output CacheTypes::CacheLine  writeLine,
    output logic                  done
);
    import CacheTypes::*;

    logic    busy;
    LineAddr lineAddr;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (memReadGrant) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            lineAddr <= missAddr;
        end
    end

    always_comb begin
        memReadReq  = busy;
        memAddr     = {lineAddr, {lineOffsetWidth{1'b0}}};
        // Line goes straight into the array in the grant cycle
        writeEnable = busy && memReadGrant;
        writeIndex  = lineAddr[indexWidth-1:0];
        writeTag    = lineAddr[$bits(LineAddr)-1:indexWidth];
        writeLine   = memReadLine;
        done        = busy && memReadGrant;
    end

    assert property (@(posedge clk) disable iff (rst)
        memReadReq && !memReadGrant |=> memReadReq && $stable(memAddr))
        else $error("ICacheRefill: request dropped or address changed before grant");

    assert property (@(posedge clk) disable iff (rst) memReadGrant |-> memReadReq)
        else $error("ICacheRefill: grant without a pending request");

endmodule

`default_nettype wire

/* source/TlbAllocator.sv */
//--------------------------------------------------------------------------
// Round-robin victim selection for software TLB writes.
// No check is made for a page that is already mapped, so software must
// not write the same virtual page twice without an invalidate between.
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module TlbAllocator #(
    parameter int tlbEntries = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  tlbWrite,
    input  logic                  invalidateTlb,
    output logic [tlbEntries-1:0] entryWrite,
    output logic                  entryClear
);
    localparam int pointerWidth = $clog2(tlbEntries);

    logic [pointerWidth-1:0] victim;

    // Start over from slot 0 once the TLB is cleared
    always_ff @(posedge clk) begin
        if (rst || invalidateTlb) begin
            victim <= '0;
        end else if (tlbWrite) begin
            if (victim == pointerWidth'(tlbEntries - 1)) begin
                victim <= '0;
            end else begin
                victim <= victim + 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < tlbEntries; i++) begin
            entryWrite[i] = tlbWrite && (victim == pointerWidth'(i));
        end
        entryClear = invalidateTlb;
    end

    // Every write must land in exactly one existing slot
    assert property (@(posedge clk) disable iff (rst) tlbWrite |-> $onehot(entryWrite))
        else $error("TlbAllocator: write strobe not one-hot %b", entryWrite);

endmodule

`default_nettype wire

/* source/TlbEntry.sv */
//--------------------------------------------------------------------------
// Single fully associative TLB slot.
// Clear wins over a write in the same cycle. Only the valid bit is reset,
// the stored pages are undefined until the first write.
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module TlbEntry (
    input  logic                clk,
    input  logic                rst,
    input  logic                write,
    input  logic                clear,
    input  FetchTypes::VirtPage writeVirt,
    input  FetchTypes::PhysPage writePhys,
    input  logic                writeExec,
    input  FetchTypes::VirtPage lookupPage,
    output logic                match,
    output FetchTypes::PhysPage physPage,
    output logic                exec
);
    import FetchTypes::*;

    logic    valid;
    VirtPage virtPage;

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            valid <= 1'b0;
        end else if (write) begin
            valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            virtPage <= writeVirt;
            physPage <= writePhys;
            exec     <= writeExec;
        end
    end

    assign match = valid && (virtPage == lookupPage);

endmodule

`default_nettype wire

/* source/TlbHitMerge.sv */
//--------------------------------------------------------------------------
// AND-OR merge of the per-entry TLB results, purely combinational.
// Assumes at most one entry matches; a double mapping ORs two pages.
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module TlbHitMerge #(
    parameter int tlbEntries = 4
) (
    input  logic                                 [tlbEntries-1:0] match,
    input  FetchTypes::PhysPage [tlbEntries-1:0]                  physPages,
    input  logic                                 [tlbEntries-1:0] execs,
    output logic                                                  hit,
    output FetchTypes::PhysPage                                   physPage,
    output logic                                                  exec
);
    import FetchTypes::*;

    always_comb begin
        hit      = |match;
        physPage = '0;
        exec     = 1'b0;
        for (int i = 0; i < tlbEntries; i++) begin
            physPage = physPage | (physPages[i] & {$bits(PhysPage){match[i]}});
            exec     = exec | (execs[i] & match[i]);
        end
    end

    // Two matches mean software mapped the same page twice
    always_comb begin
        assert ($isunknown(match) || $onehot0(match))
            else $error("TlbHitMerge: several entries match %b", match);
    end

endmodule

`default_nettype wire

/* verilog.f */
source/FetchTypes.sv
source/CacheTypes.sv
source/TlbAllocator.sv
source/TlbEntry.sv
source/TlbHitMerge.sv
source/ICacheArray.sv
source/ICacheRefill.sv
source/FetchUnit.sv
dv/FetchUnitTb.sv
